/* cv_ctrl.f */
hdl/cv_pkg.sv
hdl/cv_joy_router.sv
hdl/cv_keypad_encoder.sv
hdl/cv_cart_loader.sv
hdl/cv_ctrl_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_cv_ctrl.sv

/* tb/tb_cv_ctrl.sv */
`timescale 1ns/1ps

module tb_cv_ctrl;

        import cv_pkg::*;

        localparam int SEED = 50;

        logic                    clk_sys;
        logic                    rst_n;
        logic [JOY_W-1:0]        joy0;
        logic [JOY_W-1:0]        joy1;
        logic                    swap;
        logic [NUM_PLAYERS-1:0]  ctrl_p5;
        logic [NUM_PLAYERS-1:0]  ctrl_p8;
        logic                    ioctl_download;
        logic                    ioctl_wr;
        logic [IOCTL_ADDR_W-1:0] ioctl_addr;
        logic [7:0]              ioctl_index;
        logic [7:0]              ioctl_dout;
        logic                    user_reset;
        logic [CV_JOY_W-1:0]     cv_joy0;
        logic [CV_JOY_W-1:0]     cv_joy1;
        logic [NUM_PLAYERS-1:0]  ctrl_p1;
        logic [NUM_PLAYERS-1:0]  ctrl_p2;
        logic [NUM_PLAYERS-1:0]  ctrl_p3;
        logic [NUM_PLAYERS-1:0]  ctrl_p4;
        logic [NUM_PLAYERS-1:0]  ctrl_p6;
        logic [PAGE_W-1:0]       cart_pages;
        logic                    sg1000;
        logic                    extram;
        logic                    console_rst_n;

        // Reference model state
        logic [JOY_W-1:0]        w0;
        logic [JOY_W-1:0]        w1;
        logic [4:0]              pb0;
        logic [4:0]              pb1;
        logic [15:0]             exp_joy;
        logic [9:0]              exp_pins;
        logic [PAGE_W-1:0]       exp_pages;
        logic                    exp_sg;
        logic                    exp_ext;
        logic                    exp_rst_n;

        logic [2:0]              test_id;
        int                      err_count;
        int                      chk_count;
        int                      timeouts;
        int                      seed;

        tb_clkgen #(.PERIOD_NS(8.0)) u_clkgen (.clk_o(clk_sys));

        cv_ctrl_top UUT (
                .clk_sys          (clk_sys),
                .rst_n_i          (rst_n),
                .joy0_i           (joy0),
                .joy1_i           (joy1),
                .swap_i           (swap),
                .cv_joy0_o        (cv_joy0),
                .cv_joy1_o        (cv_joy1),
                .ctrl_p5_i        (ctrl_p5),
                .ctrl_p8_i        (ctrl_p8),
                .ctrl_p1_o        (ctrl_p1),
                .ctrl_p2_o        (ctrl_p2),
                .ctrl_p3_o        (ctrl_p3),
                .ctrl_p4_o        (ctrl_p4),
                .ctrl_p6_o        (ctrl_p6),
                .ioctl_download_i (ioctl_download),
                .ioctl_wr_i       (ioctl_wr),
                .ioctl_addr_i     (ioctl_addr),
                .ioctl_index_i    (ioctl_index),
                .ioctl_dout_i     (ioctl_dout),
                .user_reset_i     (user_reset),
                .cart_pages_o     (cart_pages),
                .sg1000_o         (sg1000),
                .extram_o         (extram),
                .console_rst_n_o  (console_rst_n)
        );

        tb_checker u_checker (
                .clk_sys     (clk_sys),
                .test_id_i   (test_id),
                .exp_joy_i   (exp_joy),
                .act_joy_i   ({cv_joy1, cv_joy0}),
                .exp_pins_i  (exp_pins),
                .act_pins_i  ({ctrl_p1, ctrl_p2, ctrl_p3, ctrl_p4, ctrl_p6}),
                .exp_ld_i    ({exp_pages, exp_sg, exp_ext, exp_rst_n}),
                .act_ld_i    ({cart_pages, sg1000, extram, console_rst_n}),
                .err_count_o (err_count),
                .chk_count_o (chk_count)
        );

        // ====================
        // Reference model
        // ====================

        // Scan order by host word bit: keys 0-9, asterisk, number, purple, blue
        function automatic cv_key_e key_from_word(input logic [JOY_W-1:0] w);
                int      order [KEY_SCAN_W];
                cv_key_e codes [KEY_SCAN_W];
                cv_key_e found;

                order = '{8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 6, 7, 18, 19};
                codes = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7,
                          KEY_8, KEY_9, KEY_ASTERISK, KEY_NUMBER, KEY_PURPLE, KEY_BLUE};
                found = KEY_NONE;
                for (int i = KEY_SCAN_W - 1; i >= 0; i--) begin
                        if (w[order[i]])
                                found = codes[i];
                end
                return found;
        endfunction

        // Top bit drops while any keypad button is held
        function automatic logic [7:0] console_byte(input logic [JOY_W-1:0] w);
                logic [7:0] b;

                b[7]   = (w[19:6] == '0);
                b[6]   = 1'b1;
                b[5:0] = ~w[5:0];
                return b;
        endfunction

        // Returns {nibble, fire}, both active low
        function automatic logic [4:0] pin_bits(input logic [JOY_W-1:0] w, input logic p5,
                                                input logic p8);
                logic [4:0] kp;
                logic [4:0] dir;

                kp  = p5 ? 5'b11111 : {key_from_word(w), ~w[5]};
                dir = p8 ? 5'b11111 : {~w[3], ~w[2], ~w[1], ~w[0], ~w[4]};
                return kp & dir;
        endfunction

        always_comb begin
                w0       = swap ? joy1 : joy0;
                w1       = swap ? joy0 : joy1;
                exp_joy  = {console_byte(w1), console_byte(w0)};
                pb0      = pin_bits(w0, ctrl_p5[0], ctrl_p8[0]);
                pb1      = pin_bits(w1, ctrl_p5[1], ctrl_p8[1]);
                exp_pins = {pb1[4], pb0[4], pb1[3], pb0[3], pb1[2], pb0[2],
                            pb1[1], pb0[1], pb1[0], pb0[0]};
        end

        always @(posedge clk_sys or negedge rst_n) begin
                if (!rst_n) begin
                        exp_pages <= '0;
                        exp_sg    <= 1'b0;
                        exp_ext   <= 1'b0;
                        exp_rst_n <= 1'b0;
                end else begin
                        exp_rst_n <= !(ioctl_download || user_reset);
                        if (ioctl_wr) begin
                                exp_pages <= ioctl_addr[19:14];
                                if (ioctl_addr == 0) begin
                                        exp_sg  <= (ioctl_index[4:0] == IMG_SG);
                                        exp_ext <= 1'b0;
                                end else if (exp_sg && ioctl_addr[24:13] == SG_EXTRAM_BLOCK) begin
                                        exp_ext <= (ioctl_dout == 8'hFF) &&
                                                   (ioctl_addr[12:0] == 0 || exp_ext);
                                end
                        end
                end
        end

        // ====================
        // Stimulus
        // ====================

        // Sparse random presses, roughly one bit in eight
        task automatic drive_joy(input logic [1:0] p5, input logic [1:0] p8, input logic sw);
                @(posedge clk_sys);
                joy0    <= $urandom & $urandom & $urandom;
                joy1    <= $urandom & $urandom & $urandom;
                swap    <= sw;
                ctrl_p5 <= p5;
                ctrl_p8 <= p8;
        endtask

        task automatic wait_console_rst(input logic level);
                int cycles;

                cycles = 0;
                while (console_rst_n !== level && cycles < 20) begin
                        @(negedge clk_sys);
                        cycles++;
                end
                if (console_rst_n !== level) begin
                        $display("Timeout: console reset did not reach level %0d", level);
                        timeouts++;
                end
        endtask

        // One byte per strobe, with an occasional idle cycle after it
        task automatic write_byte(input logic [IOCTL_ADDR_W-1:0] addr, input logic [7:0] data);
                @(posedge clk_sys);
                ioctl_wr   <= 1'b1;
                ioctl_addr <= addr;
                ioctl_dout <= data;
                if ($urandom_range(0, 3) == 0) begin
                        @(posedge clk_sys);
                        ioctl_wr <= 1'b0;
                end
        endtask

        task automatic run_download(input logic [4:0] kind, input logic fill_ff);
                logic [2:0]              idx_hi;
                logic [7:0]              b;
                logic [IOCTL_ADDR_W-1:0] last_addr;
                int                      n;

                idx_hi = 3'($urandom);
                @(posedge clk_sys);
                ioctl_index    <= {idx_hi, kind};
                ioctl_download <= 1'b1;
                wait_console_rst(1'b0);
                write_byte('0, 8'($urandom));
                n = $urandom_range(1, 6);
                for (int i = 1; i <= n; i++)
                        write_byte(IOCTL_ADDR_W'(i), 8'($urandom));
                // Extra RAM marker region at 2000-3FFF
                n = $urandom_range(0, 12);
                for (int i = 0; i < n; i++) begin
                        b = 8'($urandom);
                        if (fill_ff || $urandom_range(0, 2) != 0)
                                b = 8'hFF;
                        write_byte(25'h2000 + IOCTL_ADDR_W'(i), b);
                end
                last_addr = {5'd0, 20'($urandom)};
                write_byte(last_addr, 8'($urandom));
                @(posedge clk_sys);
                ioctl_wr       <= 1'b0;
                ioctl_download <= 1'b0;
                wait_console_rst(1'b1);
        endtask

        initial begin
                seed = SEED;
                void'($urandom(seed));
                rst_n          = 1'b0;
                joy0           = '0;
                joy1           = '0;
                swap           = 1'b0;
                ctrl_p5        = '1;
                ctrl_p8        = '1;
                ioctl_download = 1'b0;
                ioctl_wr       = 1'b0;
                ioctl_addr     = '0;
                ioctl_index    = '0;
                ioctl_dout     = '0;
                user_reset     = 1'b0;
                test_id        = 3'd0;
                timeouts       = 0;
                repeat (2) @(posedge clk_sys);
                rst_n <= 1'b1;
                wait_console_rst(1'b1);

                test_id <= 3'd1;
                for (int i = 0; i < 200; i++)
                        drive_joy(2'b00, 2'b11, 1'b0);

                test_id <= 3'd2;
                for (int i = 0; i < 200; i++) begin
                        case ($urandom_range(0, 3))
                                0:       drive_joy(2'b11, 2'b00, 1'b0);
                                1:       drive_joy(2'b11, 2'b11, 1'b0);
                                2:       drive_joy(2'b00, 2'b00, 1'b0);
                                default: drive_joy(2'($urandom), 2'($urandom), 1'b0);
                        endcase
                end

                test_id <= 3'd3;
                for (int i = 0; i < 200; i++)
                        drive_joy(2'($urandom), 2'($urandom), 1'($urandom));

                test_id <= 3'd4;
                for (int i = 0; i < 30 && timeouts == 0; i++)
                        run_download($urandom_range(0, 2) != 0 ? IMG_SG : IMG_CART,
                                     1'($urandom));

                test_id <= 3'd5;
                for (int i = 0; i < 10 && timeouts == 0; i++)
                        run_download(IMG_CART, 1'b0);

                test_id <= 3'd6;
                for (int i = 0; i < 10 && timeouts == 0; i++) begin
                        @(posedge clk_sys);
                        user_reset <= 1'b1;
                        ioctl_download <= 1'($urandom);
                        wait_console_rst(1'b0);
                        repeat ($urandom_range(1, 4)) @(posedge clk_sys);
                        user_reset <= 1'b0;
                        ioctl_download <= 1'b0;
                        wait_console_rst(1'b1);
                end

                @(negedge clk_sys);
                $display("Checks: %0d, errors: %0d, timeouts: %0d", chk_count, err_count, timeouts);
                if (err_count == 0 && timeouts == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
        input  logic                      clk_sys,
        input  logic [2:0]                test_id_i,
        // Console joystick bytes, player 1 on top
        input  logic [15:0]               exp_joy_i,
        input  logic [15:0]               act_joy_i,
        // Pins p1, p2, p3, p4, p6, two players each
        input  logic [9:0]                exp_pins_i,
        input  logic [9:0]                act_pins_i,
        // Pages, sg1000, extram, console reset
        input  logic [cv_pkg::PAGE_W+2:0] exp_ld_i,
        input  logic [cv_pkg::PAGE_W+2:0] act_ld_i,
        output int                        err_count_o,
        output int                        chk_count_o
);

        int err_cnt;
        int chk_cnt;

        function automatic string test_name(input logic [2:0] id);
                case (id)
                        3'd1:    return "keypad_priority";
                        3'd2:    return "dir_fire1";
                        3'd3:    return "swap_bytes";
                        3'd4:    return "sg_extram";
                        3'd5:    return "page_count";
                        3'd6:    return "console_reset";
                        default: return "reset_state";
                endcase
        endfunction

        task automatic compare_field(input string field, input logic [15:0] exp,
                                     input logic [15:0] act);
                if (act !== exp) begin
                        err_cnt++;
                        $display("MISMATCH test=%s field=%s expected=%h actual=%h @%0t",
                                 test_name(test_id_i), field, exp, act, $time);
                end
        endtask

        initial begin
                err_cnt = 0;
                chk_cnt = 0;
        end

        // Sample midway through the cycle, all outputs are settled here
        always @(negedge clk_sys) begin
                chk_cnt++;
                compare_field("cv_joy", exp_joy_i, act_joy_i);
                compare_field("ctrl_pins", 16'(exp_pins_i), 16'(act_pins_i));
                compare_field("loader", 16'(exp_ld_i), 16'(act_ld_i));
        end

        assign err_count_o = err_cnt;
        assign chk_count_o = chk_cnt;

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
        parameter real PERIOD_NS = 8.0
) (
        output logic clk_o
);

        // Free-running system clock, starts low
        initial begin
                clk_o = 1'b0;
                forever begin
                        #(PERIOD_NS / 2.0);
                        clk_o = ~clk_o;
                end
        end

endmodule

/* hdl/cv_ctrl_top.sv */
`timescale 1ns/1ps

module cv_ctrl_top (
        input  logic                               clk_sys,
        input  logic                               rst_n_i,

        // Host joysticks
        input  logic [cv_pkg::JOY_W-1:0]           joy0_i,
        input  logic [cv_pkg::JOY_W-1:0]           joy1_i,
        input  logic                               swap_i,
        output logic [cv_pkg::CV_JOY_W-1:0]        cv_joy0_o,
        output logic [cv_pkg::CV_JOY_W-1:0]        cv_joy1_o,

        // Console controller ports
        input  logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p5_i,
        input  logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p8_i,
        output logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p1_o,
        output logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p2_o,
        output logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p3_o,
        output logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p4_o,
        output logic [cv_pkg::NUM_PLAYERS-1:0]     ctrl_p6_o,

        // Download stream
        input  logic                               ioctl_download_i,
        input  logic                               ioctl_wr_i,
        input  logic [cv_pkg::IOCTL_ADDR_W-1:0]    ioctl_addr_i,
        input  logic [7:0]                         ioctl_index_i,
        input  logic [7:0]                         ioctl_dout_i,
        input  logic                               user_reset_i,
        output logic [cv_pkg::PAGE_W-1:0]          cart_pages_o,
        output logic                               sg1000_o,
        output logic                               extram_o,
        output logic                               console_rst_n_o
);

        import cv_pkg::*;

        logic [KEYPAD_W-1:0] keypad [NUM_PLAYERS];
        logic [3:0]          nibble [NUM_PLAYERS];
        logic                fire_n [NUM_PLAYERS];

        // ====================
        // Joystick path
        // ====================

        cv_joy_router u_router (
                .joy0_i    (joy0_i),
                .joy1_i    (joy1_i),
                .swap_i    (swap_i),
                .cv_joy0_o (cv_joy0_o),
                .cv_joy1_o (cv_joy1_o),
                .keypad_o  (keypad)
        );

        for (genvar g = 0; g < NUM_PLAYERS; g++) begin : g_player
                cv_keypad_encoder u_encoder (
                        .keypad_i      (keypad[g]),
                        .kp_sel_n_i    (ctrl_p5_i[g]),
                        .joy_sel_n_i   (ctrl_p8_i[g]),
                        .ctrl_nibble_o (nibble[g]),
                        .fire_n_o      (fire_n[g])
                );
        end

        // Nibble bit 3 goes to pin 1, bit 0 to pin 4
        always_comb begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                        ctrl_p1_o[p] = nibble[p][3];
                        ctrl_p2_o[p] = nibble[p][2];
                        ctrl_p3_o[p] = nibble[p][1];
                        ctrl_p4_o[p] = nibble[p][0];
                        ctrl_p6_o[p] = fire_n[p];
                end
        end

        // ====================
        // Cartridge download
        // ====================

        cv_cart_loader u_loader (
                .clk_sys          (clk_sys),
                .rst_n_i          (rst_n_i),
                .ioctl_download_i (ioctl_download_i),
                .ioctl_wr_i       (ioctl_wr_i),
                .ioctl_addr_i     (ioctl_addr_i),
                .ioctl_index_i    (ioctl_index_i),
                .ioctl_dout_i     (ioctl_dout_i),
                .user_reset_i     (user_reset_i),
                .cart_pages_o     (cart_pages_o),
                .sg1000_o         (sg1000_o),
                .extram_o         (extram_o),
                .console_rst_n_o  (console_rst_n_o)
        );

endmodule

/* hdl/cv_cart_loader.sv */
`timescale 1ns/1ps

module cv_cart_loader (
        input  logic                            clk_sys,
        input  logic                            rst_n_i,
        input  logic                            ioctl_download_i,
        input  logic                            ioctl_wr_i,
        input  logic [cv_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
        input  logic [7:0]                      ioctl_index_i,
        input  logic [7:0]                      ioctl_dout_i,
        input  logic                            user_reset_i,
        output logic [cv_pkg::PAGE_W-1:0]       cart_pages_o,
        output logic                            sg1000_o,
        output logic                            extram_o,
        output logic                            console_rst_n_o
);

        import cv_pkg::*;

        logic [PAGE_W-1:0] cart_pages_q;
        logic              sg1000_q;
        logic              sg1000_d;
        logic              extram_q;
        logic              extram_d;
        logic              console_rst_n_q;
        logic              first_byte;
        logic              in_extram_blk;
        img_kind_e         img_kind;

        // ====================
        // Stream decode
        // ====================

        assign first_byte    = (ioctl_addr_i == '0);
        assign in_extram_blk = (ioctl_addr_i[24:13] == SG_EXTRAM_BLOCK);
        assign img_kind      = img_kind_e'(ioctl_index_i[4:0]);

        always_comb begin
                sg1000_d = sg1000_q;
                extram_d = extram_q;
                if (first_byte) begin
                        // New image starts
                        extram_d = 1'b0;
                        sg1000_d = (img_kind == IMG_SG);
                end
                // Extra RAM claimed when the whole 2000-3FFF region reads back FF
                if (in_extram_blk && sg1000_q) begin
                        extram_d = ((ioctl_addr_i[12:0] == '0) | extram_q) & (&ioctl_dout_i);
                end
        end

        // ====================
        // Registers
        // ====================

        always_ff @(posedge clk_sys or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        cart_pages_q <= '0;
                        sg1000_q     <= 1'b0;
                        extram_q     <= 1'b0;
                end else if (ioctl_wr_i) begin
                        // Last written page wins
                        cart_pages_q <= ioctl_addr_i[19:14];
                        sg1000_q     <= sg1000_d;
                        extram_q     <= extram_d;
                end
        end

        // Console stays in reset while a download or user reset is active
        always_ff @(posedge clk_sys or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        console_rst_n_q <= 1'b0;
                end else begin
                        console_rst_n_q <= ~(ioctl_download_i | user_reset_i);
                end
        end

        assign cart_pages_o    = cart_pages_q;
        assign sg1000_o        = sg1000_q;
        assign extram_o        = extram_q;
        assign console_rst_n_o = console_rst_n_q;

endmodule

/* hdl/cv_keypad_encoder.sv */
`timescale 1ns/1ps

module cv_keypad_encoder (
        input  logic [cv_pkg::KEYPAD_W-1:0] keypad_i,
        // Keypad select, from ctrl_p5
        input  logic                        kp_sel_n_i,
        // Joystick select, from ctrl_p8
        input  logic                        joy_sel_n_i,
        output logic [3:0]                  ctrl_nibble_o,
        output logic                        fire_n_o
);

        import cv_pkg::*;

        cv_key_e    key_code_w;
        logic [3:0] kp_nibble;
        logic [3:0] dir_nibble;
        logic       kp_fire_n;
        logic       joy_fire_n;

        // Code of each scanned keypad position
        function automatic cv_key_e key_at(input int unsigned idx);
                cv_key_e code;

                case (idx)
                        0:       code = KEY_0;
                        1:       code = KEY_1;
                        2:       code = KEY_2;
                        3:       code = KEY_3;
                        4:       code = KEY_4;
                        5:       code = KEY_5;
                        6:       code = KEY_6;
                        7:       code = KEY_7;
                        8:       code = KEY_8;
                        9:       code = KEY_9;
                        10:      code = KEY_ASTERISK;
                        11:      code = KEY_NUMBER;
                        12:      code = KEY_PURPLE;
                        13:      code = KEY_BLUE;
                        default: code = KEY_NONE;
                endcase
                return code;
        endfunction

        // ====================
        // Priority scan
        // ====================

        // Walk from the top so the lowest pressed position wins
        always_comb begin
                key_code_w = KEY_NONE;
                for (int k = KEY_SCAN_W - 1; k >= 0; k--) begin
                        if (keypad_i[k]) begin
                                key_code_w = key_at(k);
                        end
                end
        end

        // ====================
        // Select gating
        // ====================

        // Keypad side, fire 2 on the keypad half
        always_comb begin
                if (!kp_sel_n_i) begin
                        kp_nibble = key_code_w;
                        kp_fire_n = ~keypad_i[KP_FIRE2];
                end else begin
                        kp_nibble = 4'b1111;
                        kp_fire_n = 1'b1;
                end
        end

        // Joystick side, up in bit 3 down to right in bit 0
        always_comb begin
                if (!joy_sel_n_i) begin
                        dir_nibble = ~{keypad_i[KP_DIR_LO], keypad_i[KP_DIR_LO + 1],
                                       keypad_i[KP_DIR_LO + 2], keypad_i[KP_DIR_LO + 3]};
                        joy_fire_n = ~keypad_i[KP_FIRE1];
                end else begin
                        dir_nibble = 4'b1111;
                        joy_fire_n = 1'b1;
                end
        end

        // Both halves pull the shared open-collector lines low
        assign ctrl_nibble_o = kp_nibble & dir_nibble;
        assign fire_n_o      = kp_fire_n & joy_fire_n;

endmodule

/* hdl/cv_joy_router.sv */
`timescale 1ns/1ps

module cv_joy_router (
        input  logic [cv_pkg::JOY_W-1:0]    joy0_i,
        input  logic [cv_pkg::JOY_W-1:0]    joy1_i,
        input  logic                        swap_i,
        output logic [cv_pkg::CV_JOY_W-1:0] cv_joy0_o,
        output logic [cv_pkg::CV_JOY_W-1:0] cv_joy1_o,
        output logic [cv_pkg::KEYPAD_W-1:0] keypad_o [cv_pkg::NUM_PLAYERS]
);

        import cv_pkg::*;

        // Player words after the optional swap
        logic [JOY_W-1:0] word [NUM_PLAYERS];

        // ====================
        // Helpers
        // ====================

        // Host word: 0-3 right/left/down/up, 4-5 fires, 6-7 asterisk/number,
        // 8-17 keys 0-9, 18-19 purple/blue
        function automatic logic [KEYPAD_W-1:0] to_keypad(input logic [JOY_W-1:0] w);
                logic [KEYPAD_W-1:0] kp;

                kp = '0;
                // Keys 0-9 at the bottom
                kp[9:0] = w[17:8];
                kp[10]  = w[6];
                kp[11]  = w[7];
                kp[12]  = w[18];
                kp[13]  = w[19];
                // Up, down, left, right
                kp[KP_DIR_LO]     = w[3];
                kp[KP_DIR_LO + 1] = w[2];
                kp[KP_DIR_LO + 2] = w[1];
                kp[KP_DIR_LO + 3] = w[0];
                kp[KP_FIRE1]      = w[4];
                kp[KP_FIRE2]      = w[5];
                return kp;
        endfunction

        // Any keypad button shows up in the top bit, bit 6 is always clear
        function automatic logic [CV_JOY_W-1:0] to_cv_joy(input logic [JOY_W-1:0] w);
                logic [CV_JOY_W-1:0] b;

                b = {|w[19:6], 1'b0, w[5:0]};
                return ~b;
        endfunction

        // ====================
        // Routing
        // ====================

        always_comb begin
                if (swap_i) begin
                        word[0] = joy1_i;
                        word[1] = joy0_i;
                end else begin
                        word[0] = joy0_i;
                        word[1] = joy1_i;
                end
        end

        always_comb begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                        keypad_o[p] = to_keypad(word[p]);
                end
        end

        assign cv_joy0_o = to_cv_joy(word[0]);
        assign cv_joy1_o = to_cv_joy(word[1]);

endmodule

/* hdl/cv_pkg.sv */
package cv_pkg;

        // ====================
        // Widths
        // ====================

        // Host joystick word
        localparam int JOY_W        = 32;
        // Reordered keypad vector, keys first and fires last
        localparam int KEYPAD_W     = 20;
        // Keys 0-9, asterisk, number, purple, blue
        localparam int KEY_SCAN_W   = 14;
        // Active-low byte read by the console
        localparam int CV_JOY_W     = 8;
        // Address bits 19..14, one page is 16 KB
        localparam int PAGE_W       = 6;
        localparam int IOCTL_ADDR_W = 25;
        localparam int NUM_PLAYERS  = 2;

        // ====================
        // Keypad codes
        // ====================

        typedef enum logic [3:0] {
                KEY_0        = 4'b0011,
                KEY_1        = 4'b1110,
                KEY_2        = 4'b1101,
                KEY_3        = 4'b0110,
                KEY_4        = 4'b0001,
                KEY_5        = 4'b1001,
                KEY_6        = 4'b0111,
                KEY_7        = 4'b1100,
                KEY_8        = 4'b1000,
                KEY_9        = 4'b1011,
                KEY_ASTERISK = 4'b1010,
                KEY_NUMBER   = 4'b0101,
                KEY_PURPLE   = 4'b0100,
                KEY_BLUE     = 4'b0010,
                KEY_NONE     = 4'b1111
        } cv_key_e;

        // Download index kinds, low five bits of ioctl_index
        typedef enum logic [4:0] {
                IMG_CART = 5'd0,
                IMG_SG   = 5'd2
        } img_kind_e;

        // Address bits 24..13 of the 2000-3FFF region
        localparam logic [11:0] SG_EXTRAM_BLOCK = 12'd1;

        // Positions in the keypad vector
        localparam int KP_DIR_LO = 14;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;

endpackage
